// File: rtl/cpu_pkg.sv
package cpu_pkg;

  typedef enum logic [5:0] {
    op_add  = 6'h00,
    op_sub  = 6'h01,
    op_and  = 6'h02,
    op_or   = 6'h03,
    op_xor  = 6'h04,
    op_shl  = 6'h05,
    op_shr  = 6'h06,
    op_addi = 6'h08,
    op_ldi  = 6'h09,
    op_cmp  = 6'h0a,
    op_beq  = 6'h10,
    op_bne  = 6'h11,
    op_blt  = 6'h12,
    op_jmp  = 6'h13,
    op_ld   = 6'h18,
    op_ldb  = 6'h19,
    op_st   = 6'h1a,
    op_stb  = 6'h1b,
    op_halt = 6'h3f
  } opcode_e;

  typedef struct packed {
    opcode_e     opcode;
    logic [3:0]  ra;  // dest or store source
    logic [3:0]  rb;  // base / first operand
    logic [3:0]  rc;
    logic [13:0] unused;
  } rtype_t;

  typedef struct packed {
    opcode_e     opcode;
    logic [3:0]  ra;
    logic [3:0]  rb;
    logic [17:0] imm;
  } itype_t;

  typedef union packed {
    rtype_t rtype;
    itype_t itype;
  } instr_u;

  typedef enum logic [2:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_shl, alu_shr, alu_pass_b
  } alu_func_e;

  typedef enum logic [2:0] {
    pc_hold, pc_plus4, pc_rel, pc_alu, pc_vector
  } pc_sel_e;

  typedef enum logic [1:0] {mar_hold, mar_alu} mar_sel_e;
  typedef enum logic [1:0] {mdr_hold, mdr_bus, mdr_reg} mdr_sel_e;
  typedef enum logic [1:0] {reg_alu, reg_mdr, reg_imm} reg_sel_e;
  typedef enum logic {alu1_reg, alu1_pc} alu1_sel_e;
  typedef enum logic [1:0] {alu2_reg, alu2_simm, alu2_four} alu2_sel_e;

  typedef struct packed {
    pc_sel_e   pc_sel;
    mar_sel_e  mar_sel;
    mdr_sel_e  mdr_sel;
    reg_sel_e  reg_sel;
    alu1_sel_e alu1_sel;
    alu2_sel_e alu2_sel;
    alu_func_e alu_func;
    logic      ir_write;
    logic      ccr_write;
    logic      reg_write;
    logic      addr_sel;   // bus address from mar
    logic      byte_mode;
  } ctrl_t;

  typedef struct packed {
    logic carry;
    logic less;
    logic zero;
  } flags_t;

  localparam logic [31:0] vector_base = 32'h0000_0100;
  localparam logic [3:0]  exc_illegal = 4'd1;

endpackage

// File: rtl/cpu_alu.sv
`timescale 1ns/1ps

module cpu_alu (
  input  logic [31:0]        a,
  input  logic [31:0]        b,
  input  cpu_pkg::alu_func_e func,
  output logic [31:0]        result,
  output logic               carry,
  output logic               negative,
  output logic               overflow,
  output logic               zero
);
  import cpu_pkg::*;

  logic [32:0] sum;

  always_comb begin
    sum = {1'b0, a} + {1'b0, b};
    carry = 1'b0;
    overflow = 1'b0;
    case (func)
      alu_add: begin
        result = sum[31:0];
        carry = sum[32];
        overflow = (a[31] == b[31]) && (sum[31] != a[31]);
      end
      alu_sub: begin
        sum = {1'b0, a} - {1'b0, b};
        result = sum[31:0];
        carry = sum[32];  // borrow out
        overflow = (a[31] != b[31]) && (sum[31] != a[31]);
      end
      alu_and: result = a & b;
      alu_or:  result = a | b;
      alu_xor: result = a ^ b;
      alu_shl: result = a << b[4:0];
      alu_shr: result = a >> b[4:0];  // logical
      default: result = b;
    endcase
  end

  assign negative = result[31];
  assign zero = (result == 32'd0);

endmodule

// File: rtl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic        clk,
  input  logic        reset_n,
  input  logic [3:0]  read_addr1,
  input  logic [3:0]  read_addr2,
  input  logic [3:0]  write_addr,
  input  logic [31:0] write_data,
  input  logic        write_en,
  output logic [31:0] data1,
  output logic [31:0] data2
);

  logic [31:0] regs [16];

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (write_en && write_addr != 4'd0) begin
      regs[write_addr] <= write_data;
    end
  end

  // r0 always reads zero
  assign data1 = (read_addr1 == 4'd0) ? 32'd0 : regs[read_addr1];
  assign data2 = (read_addr2 == 4'd0) ? 32'd0 : regs[read_addr2];

endmodule

// File: rtl/cpu_control.sv
`timescale 1ns/1ps

module cpu_control (
  input  logic             clk,
  input  logic             reset_n,
  input  logic             waitrequest,
  input  cpu_pkg::instr_u  ir,
  input  cpu_pkg::flags_t  ccr,
  output cpu_pkg::ctrl_t   ctrl,
  output logic             read,
  output logic             write,
  output logic             halt,
  output logic [3:0]       exception
);
  import cpu_pkg::*;

  typedef enum logic [2:0] {
    s_fetch, s_decode, s_execute, s_memory, s_writeback, s_vector, s_halted
  } state_e;

  state_e    state, state_next;
  opcode_e   op;
  alu_func_e alu_fn;
  logic      is_rop, is_load, is_store, is_byte, use_simm, illegal;

  assign op = ir.rtype.opcode;

  // opcode classes
  always_comb begin
    alu_fn = alu_add;
    is_rop = 1'b0;
    is_load = 1'b0;
    is_store = 1'b0;
    is_byte = (op == op_ldb) || (op == op_stb);
    use_simm = 1'b0;
    illegal = 1'b0;
    case (op)
      op_add:  is_rop = 1'b1;
      op_sub: begin
        is_rop = 1'b1;
        alu_fn = alu_sub;
      end
      op_and: begin
        is_rop = 1'b1;
        alu_fn = alu_and;
      end
      op_or: begin
        is_rop = 1'b1;
        alu_fn = alu_or;
      end
      op_xor: begin
        is_rop = 1'b1;
        alu_fn = alu_xor;
      end
      op_shl: begin
        is_rop = 1'b1;
        alu_fn = alu_shl;
      end
      op_shr: begin
        is_rop = 1'b1;
        alu_fn = alu_shr;
      end
      op_cmp:  alu_fn = alu_sub;
      op_addi, op_jmp: use_simm = 1'b1;
      op_ld, op_ldb: begin
        is_load = 1'b1;
        use_simm = 1'b1;
      end
      op_st, op_stb: begin
        is_store = 1'b1;
        use_simm = 1'b1;
      end
      op_ldi, op_beq, op_bne, op_blt, op_halt: ;
      default: illegal = 1'b1;
    endcase
  end

  always_comb begin
    state_next = state;
    case (state)
      s_fetch:     if (read && !waitrequest) state_next = s_decode;
      s_decode: begin
        if (illegal) state_next = s_vector;
        else if (op == op_halt) state_next = s_halted;
        else state_next = s_execute;
      end
      s_execute: begin
        if (is_load || is_store) state_next = s_memory;
        else if (is_rop || op == op_addi || op == op_ldi) state_next = s_writeback;
        else state_next = s_fetch;  // cmp, branches, jmp
      end
      s_memory:    if (!waitrequest) state_next = is_load ? s_writeback : s_fetch;
      s_writeback: state_next = s_fetch;
      s_vector:    state_next = s_fetch;
      default:     state_next = s_halted;
    endcase
  end

  always_comb begin
    ctrl = '0;
    case (state)
      s_fetch: begin
        if (read) begin  // nothing loads until the strobe is up
          ctrl.ir_write = 1'b1;
          ctrl.pc_sel = pc_plus4;
          ctrl.alu1_sel = alu1_pc;
          ctrl.alu2_sel = alu2_four;
        end
      end
      s_decode: if (is_store) ctrl.mdr_sel = mdr_reg;  // store data via port 1
      s_execute: begin
        ctrl.alu_func = alu_fn;
        ctrl.alu2_sel = use_simm ? alu2_simm : alu2_reg;
        case (op)
          op_cmp: ctrl.ccr_write = 1'b1;
          op_beq: ctrl.pc_sel = ccr.zero ? pc_rel : pc_hold;
          op_bne: ctrl.pc_sel = ccr.zero ? pc_hold : pc_rel;
          op_blt: ctrl.pc_sel = ccr.less ? pc_rel : pc_hold;
          op_jmp: ctrl.pc_sel = pc_alu;
          default: if (is_load || is_store) ctrl.mar_sel = mar_alu;
        endcase
      end
      s_memory: begin
        ctrl.addr_sel = 1'b1;
        ctrl.byte_mode = is_byte;
        if (is_load) ctrl.mdr_sel = mdr_bus;
      end
      s_writeback: begin
        ctrl.reg_write = 1'b1;
        if (is_load) ctrl.reg_sel = reg_mdr;
        else if (op == op_ldi) ctrl.reg_sel = reg_imm;
      end
      s_vector: ctrl.pc_sel = pc_vector;
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= s_fetch;
      read <= 1'b0;
      write <= 1'b0;
    end else begin
      state <= state_next;
      read <= (state_next == s_fetch) || (state_next == s_memory && is_load);
      write <= (state_next == s_memory) && is_store;
    end
  end

  assign halt = (state == s_halted);
  assign exception = (state == s_vector) ? exc_illegal : 4'h0;

  assert property (@(posedge clk) disable iff (!reset_n) !(read && write));

  // only reset leaves the halted state
  assert property (@(posedge clk) disable iff (!reset_n) !$fell(halt));

endmodule

// File: rtl/cpu_datapath.sv
`timescale 1ns/1ps

module cpu_datapath (
  input  logic             clk,
  input  logic             reset_n,
  input  logic             waitrequest,
  input  cpu_pkg::ctrl_t   ctrl,
  input  logic [3:0]       exception,
  input  logic [31:0]      readdata,
  output cpu_pkg::instr_u  ir,
  output cpu_pkg::flags_t  ccr,
  output logic [31:0]      address,
  output logic [31:0]      writedata,
  output logic [3:0]       byteenable
);
  import cpu_pkg::*;

  logic [31:0] pc, mar, mdr, aluval;
  logic [31:0] pc_next, mar_next, mdr_next;
  logic [31:0] simm, uimm, busin;
  logic [31:0] alu_in1, alu_in2, alu_out;
  logic [31:0] reg_data_in, reg_data1, reg_data2;
  logic [3:0]  read_addr1;
  logic        alu_carry, alu_negative, alu_overflow, alu_zero;
  logic        bus_wait;

  assign simm = {{14{ir.itype.imm[17]}}, ir.itype.imm};
  assign uimm = {14'd0, ir.itype.imm};

  // strobe is up in fetch and memory only
  assign bus_wait = waitrequest && (ctrl.ir_write || ctrl.addr_sel);

  assign read_addr1 = (ctrl.mdr_sel == mdr_reg) ? ir.itype.ra : ir.itype.rb;

  assign address = ctrl.addr_sel ? mar : pc;
  assign byteenable = ctrl.byte_mode ? (4'b0001 << address[1:0]) : 4'b1111;

  // byte lane steering
  always_comb begin
    case (byteenable)
      4'b0001: busin = {24'd0, readdata[7:0]};
      4'b0010: busin = {24'd0, readdata[15:8]};
      4'b0100: busin = {24'd0, readdata[23:16]};
      4'b1000: busin = {24'd0, readdata[31:24]};
      default: busin = readdata;
    endcase
    if (ctrl.byte_mode) writedata = {24'd0, mdr[7:0]} << {address[1:0], 3'b000};
    else writedata = mdr;
  end

  always_comb begin
    alu_in1 = (ctrl.alu1_sel == alu1_pc) ? pc : reg_data1;
    case (ctrl.alu2_sel)
      alu2_simm: alu_in2 = simm;
      alu2_four: alu_in2 = 32'd4;
      default:   alu_in2 = reg_data2;
    endcase
    case (ctrl.pc_sel)
      pc_plus4, pc_alu: pc_next = alu_out;
      pc_rel:    pc_next = pc + {simm[29:0], 2'b00};  // pc already past this instr
      pc_vector: pc_next = vector_base + {26'd0, exception, 2'b00};
      default:   pc_next = pc;
    endcase
    mar_next = (ctrl.mar_sel == mar_alu) ? alu_out : mar;
    case (ctrl.mdr_sel)
      mdr_bus: mdr_next = busin;
      mdr_reg: mdr_next = reg_data1;
      default: mdr_next = mdr;
    endcase
    case (ctrl.reg_sel)
      reg_mdr: reg_data_in = mdr;
      reg_imm: reg_data_in = uimm;
      default: reg_data_in = aluval;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      pc <= 32'd0;
      ir <= '0;
      ccr <= '0;
    end else if (!bus_wait) begin
      pc <= pc_next;
      if (ctrl.ir_write) ir <= readdata;
      if (ctrl.ccr_write) begin
        ccr <= '{carry: alu_carry, less: alu_negative ^ alu_overflow, zero: alu_zero};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!bus_wait) begin
      mar <= mar_next;
      mdr <= mdr_next;
      aluval <= alu_out;
    end
  end

  cpu_alu alu_i (
    .a        (alu_in1),
    .b        (alu_in2),
    .func     (ctrl.alu_func),
    .result   (alu_out),
    .carry    (alu_carry),
    .negative (alu_negative),
    .overflow (alu_overflow),
    .zero     (alu_zero)
  );

  reg_file reg_file_i (
    .clk        (clk),
    .reset_n    (reset_n),
    .read_addr1 (read_addr1),
    .read_addr2 (ir.rtype.rc),
    .write_addr (ir.itype.ra),
    .write_data (reg_data_in),
    .write_en   (ctrl.reg_write && !bus_wait),
    .data1      (reg_data1),
    .data2      (reg_data2)
  );

  // byte lanes only on mar accesses
  assert property (@(posedge clk) disable iff (!reset_n)
    ctrl.byte_mode |-> ctrl.addr_sel && $onehot(byteenable));

endmodule

// File: rtl/cpu_core.sv
`timescale 1ns/1ps

module cpu_core (
  input  logic        clk,
  input  logic        reset_n,
  input  logic        waitrequest,
  input  logic [31:0] readdata,
  output logic [31:0] address,
  output logic        read,
  output logic        write,
  output logic [31:0] writedata,
  output logic [3:0]  byteenable,
  output logic        halt,
  output logic [3:0]  exception
);
  import cpu_pkg::*;

  ctrl_t  ctrl;
  instr_u ir;
  flags_t ccr;

  cpu_control control_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .waitrequest (waitrequest),
    .ir          (ir),
    .ccr         (ccr),
    .ctrl        (ctrl),
    .read        (read),
    .write       (write),
    .halt        (halt),
    .exception   (exception)
  );

  cpu_datapath datapath_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .waitrequest (waitrequest),
    .ctrl        (ctrl),
    .exception   (exception),
    .readdata    (readdata),
    .ir          (ir),
    .ccr         (ccr),
    .address     (address),
    .writedata   (writedata),
    .byteenable  (byteenable)
  );

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk
);

  initial clk = 1'b0;

  always #50 clk = ~clk;  // 100 ns period

endmodule

// File: verif/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;
  import cpu_pkg::*;

  localparam int rec_base = 256;  // first store record word
  localparam int golden_words = 512;
  localparam logic [31:0] marker_addr = 32'h0000_03fc;

  logic        clk;
  logic        reset_n;
  logic        waitrequest;
  logic [31:0] readdata;
  logic [31:0] address;
  logic        read;
  logic        write;
  logic [31:0] writedata;
  logic [3:0]  byteenable;
  logic        halt;
  logic [3:0]  exception;

  logic [31:0] golden [golden_words];
  logic [31:0] mem [256];
  int          stall_left = 0;
  int          rec_ptr = 0;
  int          errors = 0;
  int          test_errors = 0;
  int          tests_done = 0;
  int          cycles = 0;
  int          limit = 0;
  int          exc_count = 0;
  logic        expect_vector = 1'b0;

  tb_clock clock_i (.clk(clk));

  cpu_core dut_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .waitrequest (waitrequest),
    .readdata    (readdata),
    .address     (address),
    .read        (read),
    .write       (write),
    .writedata   (writedata),
    .byteenable  (byteenable),
    .halt        (halt),
    .exception   (exception)
  );

  task automatic report_test(input int num);
    $display("test %0d: %s, %0d errors", num, (errors == test_errors) ? "ok" : "bad",
             errors - test_errors);
    test_errors = errors;
    tests_done++;
  endtask

  task automatic check_store();
    logic [31:0] exp_addr;
    logic [31:0] exp_data;
    logic [3:0]  exp_be;
    exp_addr = golden[rec_base + rec_ptr * 3];
    exp_data = golden[rec_base + rec_ptr * 3 + 1];
    exp_be = golden[rec_base + rec_ptr * 3 + 2][3:0];
    if (exp_addr == 32'hffff_ffff) begin
      $display("unexpected store to address %h", address);
      errors++;
    end else begin
      if (address !== exp_addr) begin
        $display("CHECK FAILED address: got %h expected %h", address, exp_addr);
        errors++;
      end
      if (writedata !== exp_data) begin
        $display("CHECK FAILED writedata: got %h expected %h", writedata, exp_data);
        errors++;
      end
      if (byteenable !== exp_be) begin
        $display("CHECK FAILED byteenable: got %h expected %h", byteenable, exp_be);
        errors++;
      end
      rec_ptr++;
      if (exp_addr == marker_addr) begin
        if (exp_data == 32'd5 && exc_count != 1) begin
          $display("illegal opcode raised %0d exceptions instead of one", exc_count);
          errors++;
        end
        report_test(int'(exp_data));
      end
    end
  endtask

  task automatic write_mem();
    for (int i = 0; i < 4; i++) begin
      if (byteenable[i]) mem[address[9:2]][i*8 +: 8] = writedata[i*8 +: 8];
    end
  endtask

  // memory model, 1 to 4 wait cycles per access
  always @(posedge clk) begin
    if (read || write) begin
      if (waitrequest) begin
        if (stall_left == 0) begin
          waitrequest <= 1'b0;
          readdata <= mem[address[9:2]];
        end else begin
          stall_left = stall_left - 1;
        end
      end else begin
        waitrequest <= 1'b1;
        stall_left = int'($urandom % 4);
        if (write) begin
          check_store();
          write_mem();
        end else if (expect_vector) begin
          if (address !== vector_base + 32'd4) begin
            $display("CHECK FAILED address: got %h expected %h", address,
                     vector_base + 32'd4);
            errors++;
          end
          expect_vector = 1'b0;
        end
      end
    end
    if (reset_n && exception != 4'h0) begin
      exc_count++;
      expect_vector = 1'b1;
      if (exception !== exc_illegal) begin
        $display("CHECK FAILED exception: got %h expected %h", exception, exc_illegal);
        errors++;
      end
    end
    if (halt && (read || write)) begin
      $display("bus strobe seen after halt");
      errors++;
    end
  end

  always @(posedge clk) begin
    if (reset_n) cycles++;
    if (cycles > limit) begin
      $display("timeout waiting for halt");
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    int prog_words;
    prog_words = 0;
    void'($urandom(16));
    reset_n <= 1'b0;
    waitrequest <= 1'b1;
    readdata <= 32'd0;
    for (int i = 0; i < golden_words; i++) golden[i] = 32'd0;
    $readmemh("verif/cpu_golden.hex", golden);
    for (int i = 0; i < 256; i++) begin
      mem[i] = golden[i];
      if (i < 192 && golden[i] != 32'd0) prog_words++;  // below the data area
    end
    limit = prog_words * 5 * 4 * 2;
    repeat (5) @(posedge clk);
    reset_n <= 1'b1;
    while (!halt) @(posedge clk);
    repeat (20) @(posedge clk);
    if (!halt) begin
      $display("halt dropped before reset");
      errors++;
    end
    if (golden[rec_base + rec_ptr * 3] != 32'hffff_ffff) begin
      $display("expected stores missing, stopped at record %0d", rec_ptr);
      errors++;
    end
    report_test(6);
    $display("tests %0d, stores checked %0d, errors %0d", tests_done, rec_ptr, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: verif/cpu_golden.hex
// program image from word 0, vector slot at word 0x41, load data at word 0xc0
// store records from word 0x100, one per line: address data byteenable
@000
24401234 248000ff 00c48000 68c00200 04c84000 68c00204 08c48000 68c00208
0cc48000 68c0020c 10c48000 68c00210 25000004 14c50000 68c00214 18c50000
68c00218 20cbff00 68c0021c 25400001 694003fc 258001a5 6d800220 6d800225
6d80022a 6d80022f 69800230 25400002 694003fc 61c00300 69c00234 66000301
6a000238 66000303 6a00023c 25400003 694003fc 28044000 40000001 68400240
44000001 68800240 28084000 48000001 68400244 28048000 48000001 68400244
264000d0 4c240000 68400248 68400248 68800248 25400004 694003fc 1c000000
@041
25400005 694003fc fc000000
@0c0
8badf00d
@100
00000200 00001333 0000000f
00000204 ffffeecb 0000000f
00000208 00000034 0000000f
0000020c 000012ff 0000000f
00000210 000012cb 0000000f
00000214 00012340 0000000f
00000218 00000123 0000000f
0000021c ffffffff 0000000f
000003fc 00000001 0000000f
00000220 000000a5 00000001
00000225 0000a500 00000002
0000022a 00a50000 00000004
0000022f a5000000 00000008
00000230 000001a5 0000000f
000003fc 00000002 0000000f
00000234 8badf00d 0000000f
00000238 000000f0 0000000f
0000023c 0000008b 0000000f
000003fc 00000003 0000000f
00000240 000000ff 0000000f
00000244 00001234 0000000f
00000248 000000ff 0000000f
000003fc 00000004 0000000f
000003fc 00000005 0000000f
ffffffff 00000000 00000000

// File: verilog.f
rtl/cpu_pkg.sv
rtl/cpu_alu.sv
rtl/reg_file.sv
rtl/cpu_control.sv
rtl/cpu_datapath.sv
rtl/cpu_core.sv
verif/tb_clock.sv
verif/cpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= verilog.f
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
DATA := verif/cpu_golden.hex
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN) $(DATA)
	./$(BIN) | tee $(LOG)
	grep -q '\*\*\* TEST PASSED \*\*\*' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
